//--- vlog.f
+incdir+include
design/rv_pkg.sv
design/control.sv
design/alu.sv
design/reg_file.sv
design/sign_extend.sv
design/rv_core.sv
verif/tb_rv_core.sv

//--- include/rv_asm.svh
`ifndef RV_ASM_SVH
`define RV_ASM_SVH

// Instruction encoders, rv_pkg must be imported where this is included

function automatic word_t enc_r(logic [6:0] f7, reg_addr_t rd, reg_addr_t rs1,
                                reg_addr_t rs2, funct3_t f3);
    return {f7, rs2, rs1, f3, rd, OP_ALU_REG};
endfunction

function automatic word_t enc_i(opcode_t op, funct3_t f3, reg_addr_t rd,
                                reg_addr_t rs1, word_t imm);
    return {imm[11:0], rs1, f3, rd, op};
endfunction

function automatic word_t enc_lw(reg_addr_t rd, reg_addr_t rs1, word_t imm);
    return enc_i(OP_LOAD, F3_LW, rd, rs1, imm);
endfunction

function automatic word_t enc_sw(reg_addr_t rs2, reg_addr_t rs1, word_t imm);
    return {imm[11:5], rs2, rs1, F3_SW, imm[4:0], OP_STORE};
endfunction

function automatic word_t enc_addi(reg_addr_t rd, reg_addr_t rs1, word_t imm);
    return enc_i(OP_ALU_IMM, F3_ADD, rd, rs1, imm);
endfunction

function automatic word_t enc_andi(reg_addr_t rd, reg_addr_t rs1, word_t imm);
    return enc_i(OP_ALU_IMM, F3_AND, rd, rs1, imm);
endfunction

function automatic word_t enc_ori(reg_addr_t rd, reg_addr_t rs1, word_t imm);
    return enc_i(OP_ALU_IMM, F3_OR, rd, rs1, imm);
endfunction

function automatic word_t enc_slti(reg_addr_t rd, reg_addr_t rs1, word_t imm);
    return enc_i(OP_ALU_IMM, F3_SLT, rd, rs1, imm);
endfunction

function automatic word_t enc_add(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return enc_r(7'b0000000, rd, rs1, rs2, F3_ADD);
endfunction

function automatic word_t enc_sub(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return enc_r(7'b0100000, rd, rs1, rs2, F3_ADD);
endfunction

function automatic word_t enc_and(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return enc_r(7'b0000000, rd, rs1, rs2, F3_AND);
endfunction

function automatic word_t enc_or(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return enc_r(7'b0000000, rd, rs1, rs2, F3_OR);
endfunction

function automatic word_t enc_slt(reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2);
    return enc_r(7'b0000000, rd, rs1, rs2, F3_SLT);
endfunction

// Byte offset, bit 0 dropped
function automatic word_t enc_beq(reg_addr_t rs1, reg_addr_t rs2, word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, F3_BEQ, imm[4:1], imm[11], OP_BRANCH};
endfunction

function automatic word_t enc_jal(reg_addr_t rd, word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
endfunction

function automatic word_t enc_lui(reg_addr_t rd, logic [19:0] imm20);
    return {imm20, rd, OP_LUI};
endfunction

function automatic word_t enc_auipc(reg_addr_t rd, logic [19:0] imm20);
    return {imm20, rd, OP_AUIPC};
endfunction

`endif

//--- verif/tb_rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_core
    import rv_pkg::*;
;

    localparam int    CLK_PERIOD      = 10;
    localparam int    RESET_CYCLES    = 8;
    localparam int    WATCHDOG_MARGIN = 20;   // Cycles on top of the program length
    localparam int    IMEM_WORDS      = 128;
    localparam int    DMEM_WORDS      = 256;
    localparam word_t LFSR_SEED       = 32'h5710;
    localparam word_t LFSR_TAPS       = 32'h8020_0003;

    logic  clk;
    logic  reset;
    word_t pc;
    word_t instr;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_write;
    word_t mem_rdata;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    int    prog_len;
    word_t lfsr_state;

    // Instruction-level model state
    word_t exp_pc;
    word_t exp_regs [REG_COUNT];
    word_t exp_mem [DMEM_WORDS];
    logic  exp_store;
    word_t exp_store_addr;
    word_t exp_store_data;

    `include "rv_asm.svh"

    rv_core u_dut (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .instr     (instr),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_write (mem_write),
        .mem_rdata (mem_rdata)
    );

    // Combinational memory ports
    assign instr     = imem[pc[8:2]];
    assign mem_rdata = dmem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_write)
            dmem[mem_addr[9:2]] <= mem_wdata;
    end

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(string name, word_t got, word_t expected);
        abort_run($sformatf("Mismatch at %0t ns: %s got %h expected %h",
                            $time, name, got, expected));
    endtask

    // Galois LFSR stepped once per bit
    function automatic word_t rand_bits(int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic word_t fill_word(int idx);
        word_t a;
        a = word_t'(idx) << 2;
        return (a * 32'h9E37_79B1) ^ 32'h0F0F_5A5A; // Every address bit matters
    endfunction

    function automatic word_t isa_alu(funct3_t f3, logic alt, word_t a, word_t b);
        case (f3)
            F3_ADD:  return alt ? a - b : a + b;
            F3_AND:  return a & b;
            F3_OR:   return a | b;
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic emit(word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic build_program();
        word_t r;
        // Store at pc 0 sits in the DUT while reset is high
        emit(enc_sw(5'd0, 5'd0, 32'h300));
        // ALU with immediates, random operands
        emit(enc_addi(5'd1, 5'd0, rand_bits(12)));
        emit(enc_addi(5'd2, 5'd0, rand_bits(12)));
        emit(enc_andi(5'd3, 5'd1, rand_bits(12)));
        emit(enc_ori(5'd4, 5'd2, rand_bits(12)));
        emit(enc_slti(5'd5, 5'd1, rand_bits(12)));
        emit(enc_addi(5'd6, 5'd0, -32'sd5));      // Negative operand for slt
        emit(enc_add(5'd7, 5'd1, 5'd2));
        emit(enc_sub(5'd8, 5'd1, 5'd2));
        emit(enc_and(5'd9, 5'd1, 5'd2));
        emit(enc_or(5'd10, 5'd1, 5'd2));
        emit(enc_slt(5'd11, 5'd6, 5'd2));
        emit(enc_slt(5'd12, 5'd2, 5'd6));
        emit(enc_slt(5'd13, 5'd6, 5'd6));
        for (int k = 1; k <= 13; k++)
            emit(enc_sw(reg_addr_t'(k), 5'd0, 32'h100 + 4 * (k - 1)));
        // Read back and copy elsewhere
        emit(enc_lw(5'd14, 5'd0, 32'h100));
        emit(enc_lw(5'd15, 5'd0, 32'h104));
        emit(enc_lw(5'd16, 5'd0, 32'h040)); // Untouched fill word
        emit(enc_sw(5'd14, 5'd0, 32'h200));
        emit(enc_sw(5'd15, 5'd0, 32'h204));
        emit(enc_sw(5'd16, 5'd0, 32'h208));
        // beq taken and then not taken
        emit(enc_addi(5'd17, 5'd0, 32'd7));
        emit(enc_addi(5'd18, 5'd0, 32'd7));
        emit(enc_beq(5'd17, 5'd18, 32'd8));
        emit(enc_addi(5'd19, 5'd0, 32'd1));   // Skipped
        emit(enc_addi(5'd20, 5'd0, 32'd2));
        emit(enc_beq(5'd17, 5'd0, 32'd8));
        emit(enc_addi(5'd21, 5'd0, 32'd3));
        emit(enc_sw(5'd19, 5'd0, 32'h20C));
        emit(enc_sw(5'd20, 5'd0, 32'h210));
        emit(enc_sw(5'd21, 5'd0, 32'h214));
        // jal over two instructions with the link exposed by a store
        emit(enc_jal(5'd22, 32'd12));
        emit(enc_addi(5'd23, 5'd0, 32'd9));
        emit(enc_addi(5'd23, 5'd0, 32'd10));
        emit(enc_sw(5'd22, 5'd0, 32'h218));
        emit(enc_sw(5'd23, 5'd0, 32'h21C));
        r = rand_bits(20);
        emit(enc_lui(5'd24, r[19:0]));
        emit(enc_sw(5'd24, 5'd0, 32'h220));
        r = rand_bits(20);
        emit(enc_auipc(5'd25, r[19:0]));
        emit(enc_sw(5'd25, 5'd0, 32'h224));
        r = rand_bits(20);
        emit({r[19:0], 5'd24, 7'b0001011});       // Unknown opcode aimed at x24
        emit(enc_sw(5'd24, 5'd0, 32'h228));
        emit(enc_jal(5'd0, 32'd0));               // Halt loop
    endtask

    task automatic reset_model();
        exp_pc = RESET_PC;
        for (int i = 0; i < REG_COUNT; i++)
            exp_regs[i] = '0;
    endtask

    task automatic step_model();
        word_t ins;
        word_t rs1v;
        word_t rs2v;
        word_t imm_i;
        word_t imm_s;
        word_t imm_u;
        word_t next_pc;
        word_t wb_val;
        logic  wb_en;
        ins     = imem[exp_pc[8:2]];
        rs1v    = exp_regs[ins[19:15]];
        rs2v    = exp_regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        imm_s   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_u   = {ins[31:12], 12'b0};
        next_pc = exp_pc + 32'd4;
        wb_en   = 1'b0;
        wb_val  = '0;
        case (ins[6:0])
            OP_LOAD: begin
                wb_en  = 1'b1;
                wb_val = exp_mem[(rs1v + imm_i) >> 2];
            end
            OP_ALU_IMM: begin
                wb_en  = 1'b1;
                wb_val = isa_alu(ins[14:12], 1'b0, rs1v, imm_i);
            end
            OP_ALU_REG: begin
                wb_en  = 1'b1;
                wb_val = isa_alu(ins[14:12], ins[30], rs1v, rs2v);
            end
            OP_STORE:  exp_mem[(rs1v + imm_s) >> 2] = rs2v;
            OP_BRANCH: begin
                if (rs1v == rs2v)
                    next_pc = exp_pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
            OP_JAL: begin
                wb_en   = 1'b1;
                wb_val  = exp_pc + 32'd4;
                next_pc = exp_pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            end
            OP_LUI: begin
                wb_en  = 1'b1;
                wb_val = imm_u;
            end
            OP_AUIPC: begin
                wb_en  = 1'b1;
                wb_val = exp_pc + imm_u;
            end
            default: ;  // No operation
        endcase
        if (wb_en && ins[11:7] != 5'd0)
            exp_regs[ins[11:7]] = wb_val;
        exp_pc = next_pc;
    endtask

    // Expected store for the instruction at exp_pc
    task automatic predict_store();
        word_t ins;
        ins            = imem[exp_pc[8:2]];
        exp_store      = (ins[6:0] == OP_STORE);
        exp_store_addr = exp_regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        exp_store_data = exp_regs[ins[24:20]];
    endtask

    always @(posedge clk) begin
        if (reset)
            reset_model();
        else
            step_model();
        predict_store();
    end

    a_pc: assert property (@(posedge clk) !reset |-> pc == exp_pc)
        else report_mismatch("pc", $sampled(pc), $sampled(exp_pc));

    a_mem_write: assert property (@(posedge clk) mem_write == (!reset && exp_store))
        else report_mismatch("mem_write", $sampled(mem_write), $sampled(!reset && exp_store));

    a_mem_addr: assert property (@(posedge clk) (!reset && exp_store) |-> mem_addr == exp_store_addr)
        else report_mismatch("mem_addr", $sampled(mem_addr), $sampled(exp_store_addr));

    a_mem_wdata: assert property (@(posedge clk) (!reset && exp_store) |-> mem_wdata == exp_store_data)
        else report_mismatch("mem_wdata", $sampled(mem_wdata), $sampled(exp_store_data));

    initial begin
        word_t halt_pc;
        int    bad_idx;
        reset      = 1'b1;
        exp_store  = 1'b0;
        exp_pc     = RESET_PC;
        lfsr_state = LFSR_SEED;
        prog_len   = 0;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = enc_addi(5'd0, 5'd0, 32'd0);
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i]    = fill_word(i);
            exp_mem[i] = fill_word(i);
        end
        build_program();
        halt_pc = word_t'((prog_len - 1) * 4);

        fork
            begin
                #((RESET_CYCLES + prog_len + WATCHDOG_MARGIN) * CLK_PERIOD);
                abort_run("Timeout: the core never reached the halt loop");
            end
        join_none

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;

        while (pc !== halt_pc)
            @(negedge clk);
        repeat (2) @(negedge clk);

        // Whole memory against the model
        bad_idx = -1;
        for (int i = 0; i < DMEM_WORDS; i++) begin
            if (bad_idx < 0 && dmem[i] !== exp_mem[i])
                bad_idx = i;
        end
        if (bad_idx >= 0) begin
            report_mismatch($sformatf("dmem[%0d]", bad_idx),
                            dmem[bad_idx], exp_mem[bad_idx]);
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/1ps
`default_nettype none

module rv_core
    import rv_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // Instruction port
    output word_t pc,
    input  word_t instr,

    // Data memory port
    output word_t mem_addr,
    output word_t mem_wdata,
    output logic  mem_write,
    input  word_t mem_rdata
);

    alu_op_t  alu_control;
    imm_sel_t imm_source;
    wb_sel_t  write_back_source;
    logic     dec_mem_write;
    logic     dec_reg_write;
    logic     reg_write_en;
    logic     alu_source;
    logic     pc_source;
    logic     second_add_source;
    logic     alu_zero;

    word_t rd1;
    word_t rd2;
    word_t imm;
    word_t src_b;
    word_t alu_result;
    word_t add_base;
    word_t target;      // Branch or jump target, also lui/auipc result
    word_t pc_plus4;
    word_t pc_next;
    word_t write_data;

    control u_control (
        .op                (instr[6:0]),
        .func3             (instr[14:12]),
        .func7             (instr[31:25]),
        .alu_zero          (alu_zero),
        .alu_control       (alu_control),
        .imm_source        (imm_source),
        .mem_write         (dec_mem_write),
        .reg_write         (dec_reg_write),
        .alu_source        (alu_source),
        .write_back_source (write_back_source),
        .pc_source         (pc_source),
        .second_add_source (second_add_source)
    );

    // No state changes while in reset
    assign reg_write_en = dec_reg_write & ~reset;
    assign mem_write    = dec_mem_write & ~reset;

    reg_file u_reg_file (
        .clk          (clk),
        .reset        (reset),
        .rs1          (instr[19:15]),
        .rs2          (instr[24:20]),
        .rd           (instr[11:7]),
        .write_enable (reg_write_en),
        .write_data   (write_data),
        .rd1          (rd1),
        .rd2          (rd2)
    );

    sign_extend u_sign_extend (
        .instr      (instr),
        .imm_source (imm_source),
        .imm        (imm)
    );

    assign src_b = alu_source ? imm : rd2; // Operand B select

    alu u_alu (
        .a           (rd1),
        .b           (src_b),
        .alu_control (alu_control),
        .result      (alu_result),
        .zero        (alu_zero)
    );

    assign mem_addr  = alu_result;
    assign mem_wdata = rd2;

    // Second adder
    assign add_base = second_add_source ? '0 : pc;
    assign target   = add_base + imm;
    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (write_back_source)
            WB_ALU:   write_data = alu_result;
            WB_MEM:   write_data = mem_rdata;
            WB_PC4:   write_data = pc_plus4;  // Link for jal
            WB_UPPER: write_data = target;
            default:  write_data = alu_result;
        endcase
    end

    assign pc_next = pc_source ? target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset)
            pc <= RESET_PC;
        else
            pc <= pc_next;
    end

endmodule

`default_nettype wire

//--- design/sign_extend.sv
`timescale 1ns/1ps
`default_nettype none

module sign_extend
    import rv_pkg::*;
(
    input  word_t    instr,
    input  imm_sel_t imm_source,
    output word_t    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_source)
            IMM_I: imm = {{20{sign}}, instr[31:20]};
            IMM_S: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            // Branch offsets are halfword aligned
            IMM_B: imm = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            IMM_J: begin
                imm = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            IMM_U: imm = {instr[31:12], 12'b0}; // Upper 20 bits, no extension
            default: imm = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import rv_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs1,
    input  reg_addr_t rs2,
    input  reg_addr_t rd,
    input  logic      write_enable,
    input  word_t     write_data,
    output word_t     rd1,
    output word_t     rd2
);

    word_t regs [REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_enable && rd != '0) begin // x0 is hardwired
            regs[rd] <= write_data;
        end
    end

    // Combinational reads
    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
    import rv_pkg::*;
(
    input  word_t   a,
    input  word_t   b,
    input  alu_op_t alu_control,
    output word_t   result,
    output logic    zero
);

    word_t sum;
    word_t diff;
    logic  less;

    assign sum  = a + b;
    assign diff = a - b;
    assign less = $signed(a) < $signed(b); // Signed compare for slt

    always_comb begin
        case (alu_control)
            ALU_ADD: result = sum;
            ALU_SUB: result = diff;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_SLT: begin
                result = '0;
                result[0] = less;
            end
            ALU_NONE: result = '0;
            default:  result = '0;
        endcase
    end

    // Used by beq
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- design/control.sv
`timescale 1ns/1ps
`default_nettype none

module control
    import rv_pkg::*;
(
    input  opcode_t    op,
    input  funct3_t    func3,
    input  logic [6:0] func7,
    input  logic       alu_zero,

    output alu_op_t    alu_control,
    output imm_sel_t   imm_source,
    output logic       mem_write,
    output logic       reg_write,
    output logic       alu_source,        // 1 selects the immediate
    output wb_sel_t    write_back_source,
    output logic       pc_source,         // 1 takes the second adder target
    output logic       second_add_source  // 1 adds to zero instead of pc
);

    alu_class_t alu_class;
    logic       branch;
    logic       jump;

    // Main decoder
    always_comb begin
        // Safe defaults leave the machine state untouched
        reg_write         = 1'b0;
        mem_write         = 1'b0;
        imm_source        = IMM_I;
        alu_class         = ALU_CLASS_NONE;
        alu_source        = 1'b0;
        write_back_source = WB_ALU;
        branch            = 1'b0;
        jump              = 1'b0;
        second_add_source = 1'b0;

        case (op)
            OP_LOAD: begin
                reg_write         = 1'b1;
                alu_class         = ALU_CLASS_MEM;
                alu_source        = 1'b1;
                write_back_source = WB_MEM;
            end
            OP_ALU_IMM: begin
                reg_write  = 1'b1;
                alu_class  = ALU_CLASS_FUNC;
                alu_source = 1'b1;
            end
            OP_STORE: begin
                mem_write  = 1'b1;
                imm_source = IMM_S;
                alu_class  = ALU_CLASS_MEM;
                alu_source = 1'b1;
            end
            OP_ALU_REG: begin
                reg_write = 1'b1;
                alu_class = ALU_CLASS_FUNC; // Operand B from rs2
            end
            OP_BRANCH: begin
                imm_source = IMM_B;
                alu_class  = ALU_CLASS_BRANCH;
                branch     = 1'b1;
            end
            OP_JAL: begin
                reg_write         = 1'b1;
                imm_source        = IMM_J;
                write_back_source = WB_PC4; // Link address
                jump              = 1'b1;
            end
            OP_LUI, OP_AUIPC: begin
                reg_write         = 1'b1;
                imm_source        = IMM_U;
                write_back_source = WB_UPPER;
                second_add_source = (op == OP_LUI); // lui adds to zero
            end
            default: begin
                // Unknown opcode, no operation
            end
        endcase
    end

    // ALU decoder
    always_comb begin
        alu_control = ALU_NONE;
        case (alu_class)
            ALU_CLASS_MEM:    alu_control = ALU_ADD;
            ALU_CLASS_BRANCH: alu_control = ALU_SUB; // beq compares by subtraction
            ALU_CLASS_FUNC: begin
                case (func3)
                    F3_ADD: begin
                        // Immediate forms have no func7, bit 5 is part of the immediate
                        if (op == OP_ALU_REG && func7[FUNCT7_ALT_BIT])
                            alu_control = ALU_SUB;
                        else
                            alu_control = ALU_ADD;
                    end
                    F3_AND:  alu_control = ALU_AND;
                    F3_OR:   alu_control = ALU_OR;
                    F3_SLT:  alu_control = ALU_SLT;
                    default: alu_control = ALU_NONE;
                endcase
            end
            default: alu_control = ALU_NONE;
        endcase
    end

    // Taken branch or any jump
    assign pc_source = (alu_zero & branch) | jump;

endmodule

`default_nettype wire

//--- design/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // Widths with a meaning of their own
    typedef logic [31:0] word_t;     // Data, address, instruction
    typedef logic [4:0]  reg_addr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [1:0]  alu_class_t; // Main decoder to ALU decoder

    // Opcodes
    localparam opcode_t OP_LOAD    = 7'b0000011;
    localparam opcode_t OP_ALU_IMM = 7'b0010011;
    localparam opcode_t OP_AUIPC   = 7'b0010111;
    localparam opcode_t OP_STORE   = 7'b0100011;
    localparam opcode_t OP_ALU_REG = 7'b0110011;
    localparam opcode_t OP_LUI     = 7'b0110111;
    localparam opcode_t OP_BRANCH  = 7'b1100011;
    localparam opcode_t OP_JAL     = 7'b1101111;

    // func3 values
    localparam funct3_t F3_ADD = 3'b000; // Also sub
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_SW  = 3'b010;
    localparam funct3_t F3_BEQ = 3'b000;

    localparam int FUNCT7_ALT_BIT = 5; // Selects sub on register ops

    // ALU class from main decoder
    localparam alu_class_t ALU_CLASS_MEM    = 2'b00; // Address calculation
    localparam alu_class_t ALU_CLASS_BRANCH = 2'b01; // Compare by subtraction
    localparam alu_class_t ALU_CLASS_FUNC   = 2'b10; // Decoded from func3
    localparam alu_class_t ALU_CLASS_NONE   = 2'b11;

    localparam word_t RESET_PC  = 32'h0000_0000;
    localparam int    REG_COUNT = 32;

    typedef enum logic [2:0] {
        ALU_ADD  = 3'b000,
        ALU_SUB  = 3'b001,
        ALU_AND  = 3'b010,
        ALU_OR   = 3'b011,
        ALU_SLT  = 3'b101,
        ALU_NONE = 3'b111
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_I = 3'b000,
        IMM_S = 3'b001,
        IMM_B = 3'b010,
        IMM_J = 3'b011,
        IMM_U = 3'b100
    } imm_sel_t;

    typedef enum logic [1:0] {
        WB_ALU   = 2'b00,
        WB_MEM   = 2'b01,
        WB_PC4   = 2'b10,
        WB_UPPER = 2'b11  // Second adder sum
    } wb_sel_t;

endpackage

`default_nettype wire
